// File: rtl/clk_rate_pkg.sv
`default_nettype none

package clk_rate_pkg;

	// ========================================
	// channel and datapath sizing
	// ========================================

	// number of independent test clocks watched by the monitor
	localparam int NUM_CHANNELS = 4;

	// width of every counter in the design, and of each reported rate
	// 16 bits leaves plenty of headroom for a 300 cycle window
	localparam int COUNT_WIDTH = 16;

	// ========================================
	// measurement window timing
	// ========================================

	// the reference window counter runs 0 .. WINDOW_LAST, so one window
	// lasts WINDOW_LAST+1 = 300 clk_ref cycles
	localparam logic [COUNT_WIDTH-1:0] WINDOW_LAST = 16'd299;

	// window count at which the synchronized edge counts are captured
	// the gap to WINDOW_LAST gives the last test edges time to cross over
	localparam logic [COUNT_WIDTH-1:0] SAMPLE_POINT = 16'd250;

	// ========================================
	// clock domain crossing
	// ========================================

	// destination flop count used by both synchronizers
	// this covers the clear release into the test domain and the
	// Gray coded count coming back to clk_ref
	localparam int SYNC_STAGES = 2;

	// fixed correction added to every captured count
	// the clear release eats three test edges at the start of a window and
	// the Gray path lags by a few cycles at the sample, which together
	// lose about six counts on a clock that matches clk_ref
	localparam logic [COUNT_WIDTH-1:0] CDC_OFFSET = 16'd6;

endpackage

`default_nettype wire

// File: rtl/reset_release_sync.sv
`timescale 1ns/1ps
`default_nettype none

module reset_release_sync (
	input  logic dest_clk,
	input  logic src_reset,
	output logic dest_reset
);

	// ========================================
	// reset release chain
	// ========================================

	// every stage is set straight away by src_reset, so the destination
	// domain sees the assert without waiting for a clock edge
	// once src_reset drops, zeros walk down the chain on dest_clk
	logic [clk_rate_pkg::SYNC_STAGES-1:0] release_chain;

	always_ff @(posedge dest_clk or posedge src_reset) begin
		if (src_reset) begin
			release_chain <= '1;
		end else begin
			// shift a zero in at the bottom of the chain
			release_chain <= {release_chain[clk_rate_pkg::SYNC_STAGES-2:0], 1'b0};
		end
	end

	// the last stage is the only one the destination logic may look at
	// its falling edge is always aligned to dest_clk, even though the
	// source may come from a completely unrelated clock
	// with two stages the reset drops on the second dest_clk edge after
	// src_reset goes low
	assign dest_reset = release_chain[clk_rate_pkg::SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: rtl/gray_count_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_count_sync (
	input  logic                                 src_clk,
	input  logic                                 src_reset,
	input  logic [clk_rate_pkg::COUNT_WIDTH-1:0] src_count,
	input  logic                                 dest_clk,
	input  logic                                 dest_reset,
	output logic [clk_rate_pkg::COUNT_WIDTH-1:0] dest_count
);

	// undo the Gray code, each binary bit is the xor of all Gray bits
	// at and above its own position
	function automatic logic [clk_rate_pkg::COUNT_WIDTH-1:0] gray_to_bin(
		input logic [clk_rate_pkg::COUNT_WIDTH-1:0] gray
	);
		logic [clk_rate_pkg::COUNT_WIDTH-1:0] bin;
		bin[clk_rate_pkg::COUNT_WIDTH-1] = gray[clk_rate_pkg::COUNT_WIDTH-1];
		for (int i = clk_rate_pkg::COUNT_WIDTH - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

	// ========================================
	// source domain
	// ========================================

	// the Gray word is registered in the source domain so that no
	// combinational glitch from the encoder can reach the other side
	// an incrementing count then changes exactly one bit per src_clk edge
	logic [clk_rate_pkg::COUNT_WIDTH-1:0] src_gray;

	always_ff @(posedge src_clk or posedge src_reset) begin
		if (src_reset) begin
			src_gray <= '0;
		end else begin
			src_gray <= src_count ^ (src_count >> 1);
		end
	end

	// ========================================
	// destination domain
	// ========================================

	// stage 0 may go metastable on the one changing bit, but whichever
	// way it settles the word is either the old or the new count
	// the later stages give it a full cycle to resolve
	logic [clk_rate_pkg::SYNC_STAGES-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] dest_gray;

	always_ff @(posedge dest_clk or posedge dest_reset) begin
		if (dest_reset) begin
			dest_gray <= '0;
		end else begin
			dest_gray <= {dest_gray[clk_rate_pkg::SYNC_STAGES-2:0], src_gray};
		end
	end

	// decode after the last stage only
	// the result is combinational, so the caller sees the count about
	// SYNC_STAGES dest_clk cycles after the source register changed
	assign dest_count = gray_to_bin(dest_gray[clk_rate_pkg::SYNC_STAGES-1]);

endmodule

`default_nettype wire

// File: rtl/clk_rate_channel.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rate_channel (
	input  logic                                 clk_ref,
	input  logic                                 async_reset_clk_test,
	input  logic                                 test_clk,
	input  logic                                 window_clear,
	output logic [clk_rate_pkg::COUNT_WIDTH-1:0] synced_count
);

	// window clear as seen in the test clock domain
	logic test_clear;

	// rising edges of test_clk since the last window clear
	logic [clk_rate_pkg::COUNT_WIDTH-1:0] edge_count;

	// ========================================
	// window clear into the test domain
	// ========================================

	// window_clear is a clk_ref level, so it cannot drive the test counter
	// reset directly without a release that races test_clk
	// the sync asserts at once and lets go on a test_clk edge
	reset_release_sync u_clear_sync (
		.dest_clk   (test_clk),
		.src_reset  (window_clear),
		.dest_reset (test_clear)
	);

	// ========================================
	// test domain edge counter
	// ========================================

	// if test_clk is dead the release chain never shifts, so test_clear
	// stays high after the first window clear and the counter is pinned
	// at zero
	// that is harmless, a stopped clock has no edges to count anyway,
	// and the checker then sees exactly CDC_OFFSET for this channel
	// the clear also arrives without any test_clk edge, so a clock that
	// stops in the middle of a window still gets a clean zero next time
	always_ff @(posedge test_clk or posedge test_clear) begin
		if (test_clear) begin
			edge_count <= '0;
		end else begin
			edge_count <= edge_count + 1'b1;
		end
	end

	// ========================================
	// count back to the reference domain
	// ========================================

	// the source side shares the test domain clear with the counter, so
	// the Gray register goes to zero along with it
	// the destination side only clears on the global reset, it just
	// follows whatever the source presents between resets
	gray_count_sync u_count_sync (
		.src_clk    (test_clk),
		.src_reset  (test_clear),
		.src_count  (edge_count),
		.dest_clk   (clk_ref),
		.dest_reset (async_reset_clk_test),
		.dest_count (synced_count)
	);

endmodule

`default_nettype wire

// File: rtl/measure_window.sv
`timescale 1ns/1ps
`default_nettype none

module measure_window (
	input  logic clk_ref,
	input  logic async_reset_clk_test,
	output logic window_clear,
	output logic sample_strobe
);

	// position inside the current window, 0 .. WINDOW_LAST
	logic [clk_rate_pkg::COUNT_WIDTH-1:0] window_count;

	// high in the last cycle of a window
	logic window_end;

	assign window_end = (window_count == clk_rate_pkg::WINDOW_LAST);

	// ========================================
	// reference window counter
	// ========================================

	// free running, rolls over to zero after WINDOW_LAST
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			window_count <= '0;
		end else if (window_end) begin
			window_count <= '0;
		end else begin
			window_count <= window_count + 1'b1;
		end
	end

	// ========================================
	// window clear
	// ========================================

	// registered so the clear sent to the test domains is glitch free,
	// it sits high for the single cycle in which the counter is back at 0
	// reset sets it, so every test counter is also held at zero while the
	// monitor is in reset
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			window_clear <= 1'b1;
		end else begin
			window_clear <= window_end;
		end
	end

	// ========================================
	// sample strobe
	// ========================================

	// one cycle pulse at the fixed sample point of each window
	// the checker registers on it, so results land one cycle later
	assign sample_strobe = (window_count == clk_rate_pkg::SAMPLE_POINT);

endmodule

`default_nettype wire

// File: rtl/rate_limit_check.sv
`timescale 1ns/1ps
`default_nettype none

module rate_limit_check (
	input  logic                                                            clk_ref,
	input  logic                                                            async_reset_clk_test,
	input  logic                                                            sample_strobe,
	input  logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] channel_count,
	input  logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] low_limit,
	input  logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] high_limit,
	output logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] rate_value,
	output logic                                                            rate_valid,
	output logic [clk_rate_pkg::NUM_CHANNELS-1:0]                           rate_low,
	output logic [clk_rate_pkg::NUM_CHANNELS-1:0]                           rate_high
);

	// captured count plus the crossing correction, per channel
	logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] corrected_count;

	// ========================================
	// offset correction
	// ========================================

	// the sum wraps at COUNT_WIDTH bits, which only matters for a test
	// clock far faster than anything the window is sized for
	always_comb begin
		for (int ch = 0; ch < clk_rate_pkg::NUM_CHANNELS; ch++) begin
			corrected_count[ch] = channel_count[ch] + clk_rate_pkg::CDC_OFFSET;
		end
	end

	// ========================================
	// capture and limit compare
	// ========================================

	// everything loads together on the strobe and then holds for the rest
	// of the window, so the flags always describe the value next to them
	// limits are compared unsigned, and a value equal to a bound counts
	// as inside the band
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			// all ones marks a channel that has never been measured
			rate_value <= '1;
			rate_low   <= '0;
			rate_high  <= '0;
		end else if (sample_strobe) begin
			for (int ch = 0; ch < clk_rate_pkg::NUM_CHANNELS; ch++) begin
				rate_value[ch] <= corrected_count[ch];
				rate_low[ch]   <= (corrected_count[ch] < low_limit[ch]);
				rate_high[ch]  <= (corrected_count[ch] > high_limit[ch]);
			end
		end
	end

	// valid is the strobe delayed by one cycle, so it lines up with the
	// freshly loaded values
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			rate_valid <= 1'b0;
		end else begin
			rate_valid <= sample_strobe;
		end
	end

endmodule

`default_nettype wire

// File: rtl/clk_rate_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rate_monitor (
	input  logic                                                            clk_ref,
	input  logic                                                            async_reset_clk_test,
	input  logic [clk_rate_pkg::NUM_CHANNELS-1:0]                           test_clk,
	input  logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] low_limit,
	input  logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] high_limit,
	output logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] rate_value,
	output logic                                                            rate_valid,
	output logic [clk_rate_pkg::NUM_CHANNELS-1:0]                           rate_low,
	output logic [clk_rate_pkg::NUM_CHANNELS-1:0]                           rate_high
);

	// clear level shared by every test domain
	logic window_clear;

	// capture pulse for the checker
	logic sample_strobe;

	// per channel counts, already in the clk_ref domain
	logic [clk_rate_pkg::NUM_CHANNELS-1:0][clk_rate_pkg::COUNT_WIDTH-1:0] channel_count;

	// ========================================
	// reference window timer
	// ========================================

	measure_window u_window (
		.clk_ref              (clk_ref),
		.async_reset_clk_test (async_reset_clk_test),
		.window_clear         (window_clear),
		.sample_strobe        (sample_strobe)
	);

	// ========================================
	// test clock channels
	// ========================================

	// one counter per test clock, all cleared by the same window
	// each channel owns its own clock domain, nothing is shared between
	// channels apart from clk_ref
	for (genvar ch = 0; ch < clk_rate_pkg::NUM_CHANNELS; ch++) begin : g_channel
		clk_rate_channel u_channel (
			.clk_ref              (clk_ref),
			.async_reset_clk_test (async_reset_clk_test),
			.test_clk             (test_clk[ch]),
			.window_clear         (window_clear),
			.synced_count         (channel_count[ch])
		);
	end

	// ========================================
	// capture and limit checking
	// ========================================

	// all results come out of here, one valid pulse per window
	rate_limit_check u_check (
		.clk_ref              (clk_ref),
		.async_reset_clk_test (async_reset_clk_test),
		.sample_strobe        (sample_strobe),
		.channel_count        (channel_count),
		.low_limit            (low_limit),
		.high_limit           (high_limit),
		.rate_value           (rate_value),
		.rate_valid           (rate_valid),
		.rate_low             (rate_low),
		.rate_high            (rate_high)
	);

endmodule

`default_nettype wire

// File: verif/tb_clk_rate_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_rate_monitor;

	// ========================================
	// constants and signals
	// ========================================

	localparam int NCH = clk_rate_pkg::NUM_CHANNELS;
	localparam int CW = clk_rate_pkg::COUNT_WIDTH;
	localparam int REF_PERIOD_NS = 4;
	localparam int RATE_TOL = 2;
	localparam int VALID_TIMEOUT = 1000;
	localparam int RANDOM_SEED = 76;
	localparam int WINDOW_CYCLES = int'(clk_rate_pkg::WINDOW_LAST) + 1;
	localparam int FIRST_VALID_CYCLES = int'(clk_rate_pkg::SAMPLE_POINT) + 1;

	logic clk_ref;
	logic async_reset_clk_test;
	logic test_clk_0;
	logic test_clk_1;
	logic test_clk_2;
	logic test_clk_3;
	logic ch3_enable;
	logic [NCH-1:0] test_clk;
	logic [NCH-1:0][CW-1:0] low_limit;
	logic [NCH-1:0][CW-1:0] high_limit;
	logic [NCH-1:0][CW-1:0] rate_value;
	logic rate_valid;
	logic [NCH-1:0] rate_low;
	logic [NCH-1:0] rate_high;

	// goes high with the first result after each reset
	logic seen_valid;

	int error_count = 0;
	int pulse_errors = 0;
	int early_errors = 0;
	int test_count = 0;
	int failed_tests = 0;

	assign test_clk = {test_clk_3, test_clk_2, test_clk_1, test_clk_0};

	clk_rate_monitor uut (
		.clk_ref              (clk_ref),
		.async_reset_clk_test (async_reset_clk_test),
		.test_clk             (test_clk),
		.low_limit            (low_limit),
		.high_limit           (high_limit),
		.rate_value           (rate_value),
		.rate_valid           (rate_valid),
		.rate_low             (rate_low),
		.rate_high            (rate_high)
	);

	// ========================================
	// clocks
	// ========================================

	always begin
		clk_ref = 1'b0;
		forever #(REF_PERIOD_NS / 2) clk_ref = ~clk_ref;
	end

	// test clocks run at 4, 6 and 10 ns, offset by a fraction of a ns
	// so no test edge ever lands on a clk_ref edge
	always begin
		test_clk_0 = 1'b0;
		#0.7;
		forever #2 test_clk_0 = ~test_clk_0;
	end

	always begin
		test_clk_1 = 1'b0;
		#0.7;
		forever #3 test_clk_1 = ~test_clk_1;
	end

	always begin
		test_clk_2 = 1'b0;
		#0.7;
		forever #5 test_clk_2 = ~test_clk_2;
	end

	// channel 3 sits dead low until enabled, then runs at 8 ns
	always begin
		test_clk_3 = 1'b0;
		#1.3;
		forever begin
			#4;
			test_clk_3 = ch3_enable ? ~test_clk_3 : 1'b0;
		end
	end

	// ========================================
	// concurrent checks
	// ========================================

	always @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			seen_valid <= 1'b0;
		end else if (rate_valid) begin
			seen_valid <= 1'b1;
		end
	end

	// a result strobe never lasts longer than one clk_ref cycle
	assert property (@(posedge clk_ref) disable iff (async_reset_clk_test)
		rate_valid |=> !rate_valid)
	else begin
		pulse_errors++;
		$display("Mismatch at %0t: rate_valid high for more than one cycle", $time);
	end

	// until the first result lands, outputs keep their reset values
	assert property (@(posedge clk_ref) disable iff (async_reset_clk_test)
		(!seen_valid && !rate_valid) |->
		(rate_value == '1 && rate_low == '0 && rate_high == '0))
	else begin
		early_errors++;
		$display("Mismatch at %0t: outputs changed before the first result", $time);
	end

	// ========================================
	// reference model and helpers
	// ========================================

	function automatic int test_period(input int ch);
		case (ch)
			0: return 4;
			1: return 6;
			2: return 10;
			default: return 8;
		endcase
	endfunction

	// edges that reach the capture flop are those from the clear release
	// up to the last one ahead of the destination stages
	// the clear release swallows SYNC_STAGES edges, the source Gray
	// register one more, and CDC_OFFSET is then added back
	function automatic int expected_rate(input int period_ns);
		int span_ns;
		span_ns = (int'(clk_rate_pkg::SAMPLE_POINT) - clk_rate_pkg::SYNC_STAGES) * REF_PERIOD_NS;
		return span_ns / period_ns - (clk_rate_pkg::SYNC_STAGES + 1)
			+ int'(clk_rate_pkg::CDC_OFFSET);
	endfunction

	function automatic int total_errors();
		return error_count + pulse_errors + early_errors;
	endfunction

	// reset holds for four rising edges and drops on a falling edge
	task automatic hold_reset();
		async_reset_clk_test = 1'b1;
		repeat (4) @(posedge clk_ref);
		@(negedge clk_ref);
		assert (rate_value == '1 && !rate_valid && rate_low == '0 && rate_high == '0)
		else begin
			error_count++;
			$display("Mismatch at %0t: outputs not in reset state during reset", $time);
		end
		async_reset_clk_test = 1'b0;
	endtask

	// returns on the falling edge inside the valid cycle, where all
	// results are settled
	task automatic wait_for_valid(output int cycles, output bit found);
		cycles = 0;
		found = 1'b0;
		while (!found && cycles < VALID_TIMEOUT) begin
			@(negedge clk_ref);
			cycles++;
			found = rate_valid;
		end
		if (!found) begin
			error_count++;
			$display("rate_valid never arrived within %0d cycles, at %0t", cycles, $time);
		end
	endtask

	task automatic check_cycles(input int cycles, input int expected, input string what);
		assert (cycles == expected) else begin
			error_count++;
			$display("Mismatch at %0t: %s took %0d cycles, expected %0d",
				$time, what, cycles, expected);
		end
	endtask

	task automatic check_rate(input int ch);
		int expected;
		int diff;
		expected = expected_rate(test_period(ch));
		diff = int'(rate_value[ch]) - expected;
		assert (diff >= -RATE_TOL && diff <= RATE_TOL) else begin
			error_count++;
			$display("Mismatch at %0t: channel %0d rate %0d, expected %0d +/- %0d",
				$time, ch, rate_value[ch], expected, RATE_TOL);
		end
	endtask

	task automatic check_flags();
		for (int ch = 0; ch < NCH; ch++) begin
			assert (rate_low[ch] == (rate_value[ch] < low_limit[ch])) else begin
				error_count++;
				$display("Mismatch at %0t: channel %0d low flag %b, value %0d, low %0d",
					$time, ch, rate_low[ch], rate_value[ch], low_limit[ch]);
			end
			assert (rate_high[ch] == (rate_value[ch] > high_limit[ch])) else begin
				error_count++;
				$display("Mismatch at %0t: channel %0d high flag %b, value %0d, high %0d",
					$time, ch, rate_high[ch], rate_value[ch], high_limit[ch]);
			end
		end
	endtask

	// bands of up to five counts placed a few counts either side of the
	// expected rate, so values land below, inside and above them
	task automatic set_random_limits();
		int low;
		for (int ch = 0; ch < NCH; ch++) begin
			low = expected_rate(test_period(ch)) - 3 + int'($urandom % 7);
			low_limit[ch] = CW'(low);
			high_limit[ch] = CW'(low + int'($urandom % 5));
		end
	endtask

	task automatic report_test(input string name, input int mark);
		int errors;
		errors = total_errors() - mark;
		test_count++;
		if (errors != 0)
			failed_tests++;
		$display("test %0d %s: %s, %0d errors", test_count, name,
			(errors == 0) ? "ok" : "failed", errors);
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin
		int cycles;
		bit found;
		int mark;
		void'($urandom(RANDOM_SEED));
		async_reset_clk_test = 1'b1;
		ch3_enable = 1'b0;
		low_limit = '0;
		high_limit = '1;

		mark = total_errors();
		hold_reset();
		wait_for_valid(cycles, found);
		if (found)
			check_cycles(cycles, FIRST_VALID_CYCLES, "first result after reset");
		report_test("reset_state", mark);

		mark = total_errors();
		repeat (3) begin
			wait_for_valid(cycles, found);
			if (found)
				check_cycles(cycles, WINDOW_CYCLES, "result spacing");
		end
		report_test("pulse_spacing", mark);

		mark = total_errors();
		wait_for_valid(cycles, found);
		for (int ch = 0; ch < 3; ch++)
			check_rate(ch);
		report_test("running_rates", mark);

		// a dead clock leaves only the offset, then the channel catches up
		mark = total_errors();
		assert (rate_value[3] == clk_rate_pkg::CDC_OFFSET) else begin
			error_count++;
			$display("Mismatch at %0t: stopped channel reads %0d", $time, rate_value[3]);
		end
		ch3_enable = 1'b1;
		repeat (2)
			wait_for_valid(cycles, found);
		check_rate(3);
		report_test("stopped_channel", mark);

		mark = total_errors();
		repeat (4) begin
			set_random_limits();
			wait_for_valid(cycles, found);
			check_flags();
		end
		report_test("random_limits", mark);

		// reset lands part way into a window
		mark = total_errors();
		repeat (100) @(negedge clk_ref);
		hold_reset();
		wait_for_valid(cycles, found);
		if (found)
			check_cycles(cycles, FIRST_VALID_CYCLES, "first result after mid-run reset");
		for (int ch = 0; ch < NCH; ch++)
			check_rate(ch);
		check_flags();
		report_test("mid_run_reset", mark);

		$display("tests: %0d run, %0d failed, %0d errors", test_count, failed_tests,
			total_errors());
		if (total_errors() == 0 && failed_tests == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
rtl/clk_rate_pkg.sv
rtl/reset_release_sync.sv
rtl/gray_count_sync.sv
rtl/clk_rate_channel.sv
rtl/measure_window.sv
rtl/rate_limit_check.sv
rtl/clk_rate_monitor.sv
verif/tb_clk_rate_monitor.sv

// File: Makefile
# Verilator build, run and lint for the clock rate monitor

TOP             ?= tb_clk_rate_monitor
FILELIST        ?= sim.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --assert --timing
BUILD_DIR       ?= obj_dir
PASS_TEXT       := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --binary --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(VERILATOR_FLAGS) --lint-only --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
